// ==== led_matrix.f ====
+incdir+design
design/led_matrix_pkg.sv
design/pixel_fetch_if.sv
design/uart_rx.sv
design/command_decoder.sv
design/framebuffer.sv
design/framebuffer_fetch.sv
design/matrix_scan.sv
design/led_matrix_top.sv
testbench/tb_led_matrix.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f led_matrix.f --top-module tb_led_matrix

out=$(./obj_dir/Vtb_led_matrix 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi

// ==== testbench/tb_led_matrix.sv ====
`timescale 1ns/1ns
`include "led_matrix_config.svh"

module tb_led_matrix;
    import led_matrix_pkg::*;

    localparam int DRIVE_DELAY   = 10;
    localparam int SLOTS         = `PANEL_HALF_HEIGHT * `COLOR_PLANES; // plane shifts per frame
    localparam int FRAME_TIMEOUT = 150000;
    localparam int NUM_PIXELS    = `PANEL_WIDTH * `PANEL_HEIGHT;

    // one host command plus the enable state expected after it
    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] arg0; // row, or enable value
        logic [7:0] arg1; // column
        logic       check;
        logic [2:0] exp_rgb;
        logic [5:0] exp_bright;
    } step_t;

    logic      clk_in;
    logic      rst_n;
    logic      rx;
    rgb_bits_t rgb_top;
    rgb_bits_t rgb_bottom;
    logic      clk_pixel;
    logic      latch;
    logic      oe_n;
    row_addr_t row_addr;

    step_t      steps [$];
    logic [7:0] fb_bytes [NUM_PIXELS * `BYTES_PER_PIXEL]; // host-side model
    bit         written [NUM_PIXELS];
    logic [2:0] cap_top [SLOTS][`PANEL_WIDTH];
    logic [2:0] cap_bottom [SLOTS][`PANEL_WIDTH];
    int         latch_count;
    int         col_count;
    int         oe_low_cycles;
    int         windows_checked;
    bit         pix_prev;
    logic [2:0] cur_rgb;
    logic [5:0] cur_bright;

    led_matrix_top u_dut (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .rx         (rx),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .clk_pixel  (clk_pixel),
        .latch      (latch),
        .oe_n       (oe_n),
        .row_addr   (row_addr)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
        if (actual !== expected)
            stop_with_failure($sformatf("Mismatch at %0t ns: %s, got %0h expected %0h",
                                        $time, what, actual, expected));
    endtask

    // panel bits for one pixel in one plane, from the rgb565 layout
    function automatic logic [2:0] expected_bits(input logic [15:0] px, input int plane,
                                                 input logic [2:0] en, input logic [5:0] bright);
        logic [5:0] red_w;
        logic [5:0] green;
        logic [5:0] blue_w;
        logic [2:0] bits;
        red_w  = {px[15:11], px[15]}; // top bit repeated as bit 0
        green  = px[10:5];
        blue_w = {px[4:0], px[4]};
        bits   = {blue_w[plane], green[plane], red_w[plane]};
        if (!bright[plane])
            bits = 3'b000;
        return bits & en;
    endfunction

    // panel monitor, sampled mid cycle
    always @(negedge clk_in) begin
        if (rst_n) begin
            if (clk_pixel && !pix_prev && col_count < `PANEL_WIDTH) begin
                cap_top[latch_count % SLOTS][col_count]    = rgb_top;
                cap_bottom[latch_count % SLOTS][col_count] = rgb_bottom;
            end
            if (clk_pixel && !pix_prev)
                col_count++;
            if (latch_count == 0)
                check(32'(oe_n), 1, "oe_n before the first latch");
            if (latch) begin
                check(32'(col_count), `PANEL_WIDTH, "pixel clock rises between latches");
                check(32'(row_addr), 32'((latch_count / `COLOR_PLANES) % `PANEL_HALF_HEIGHT),
                      "row address at latch");
                latch_count++;
                col_count = 0;
            end
            if (!oe_n) begin
                oe_low_cycles++;
            end else if (oe_low_cycles != 0) begin
                check(32'(oe_low_cycles),
                      32'(`OE_BASE_CYCLES << ((latch_count - 1) % `COLOR_PLANES)),
                      "oe_n low window length");
                windows_checked++;
                oe_low_cycles = 0;
            end
        end
        pix_prev = clk_pixel;
    end

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, value, 1'b0};
        for (i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (`UART_CLKS_PER_BIT) @(posedge clk_in);
            #DRIVE_DELAY;
        end
    endtask

    // every row pair and plane shifted again after this point
    task automatic wait_frame();
        int target;
        int cycles;
        target = latch_count + SLOTS + 1;
        cycles = 0;
        while (latch_count < target && cycles < FRAME_TIMEOUT) begin
            @(posedge clk_in);
            cycles++;
        end
        if (latch_count < target)
            stop_with_failure("Timeout: the panel scan stopped latching rows");
        #DRIVE_DELAY;
    endtask

    task automatic compare_frame();
        int         r;
        int         c;
        int         p;
        int         idx;
        int         slot;
        logic [15:0] px;
        logic [2:0] got;
        for (r = 0; r < `PANEL_HEIGHT; r++) begin
            for (c = 0; c < `PANEL_WIDTH; c++) begin
                idx = r * `PANEL_WIDTH + c;
                if (written[idx]) begin
                    px = {fb_bytes[2 * idx], fb_bytes[2 * idx + 1]};
                    for (p = 0; p < `COLOR_PLANES; p++) begin
                        slot = (r % `PANEL_HALF_HEIGHT) * `COLOR_PLANES + p;
                        got  = (r < `PANEL_HALF_HEIGHT) ? cap_top[slot][c] : cap_bottom[slot][c];
                        check(32'(got), 32'(expected_bits(px, p, cur_rgb, cur_bright)),
                              $sformatf("pixel row %0d col %0d plane %0d", r, c, p));
                    end
                end
            end
        end
    endtask

    task automatic add_step(input logic [7:0] opcode, input logic [7:0] arg0,
                            input logic [7:0] arg1, input logic check_after,
                            input logic [2:0] exp_rgb, input logic [5:0] exp_bright);
        step_t s;
        s.opcode     = opcode;
        s.arg0       = arg0;
        s.arg1       = arg1;
        s.check      = check_after;
        s.exp_rgb    = exp_rgb;
        s.exp_bright = exp_bright;
        steps.push_back(s);
    endtask

    task automatic load_table();
        add_step(CMD_WRITE_PIXEL, 8'd0, 8'd0, 1'b0, 3'b111, 6'h3f);
        add_step(CMD_WRITE_PIXEL, 8'd17, 8'd63, 1'b0, 3'b111, 6'h3f); // bottom half
        add_step(CMD_WRITE_PIXEL, 8'd9, 8'd30, 1'b0, 3'b111, 6'h3f);
        add_step(CMD_WRITE_PIXEL, 8'd25, 8'd12, 1'b0, 3'b111, 6'h3f);
        add_step(CMD_WRITE_PIXEL, 8'd15, 8'd40, 1'b1, 3'b111, 6'h3f);
        add_step(8'ha7, 8'd0, 8'd0, 1'b0, 3'b111, 6'h3f); // not an opcode
        add_step(CMD_WRITE_PIXEL, 8'd6, 8'd7, 1'b1, 3'b111, 6'h3f);
        add_step(CMD_SET_RGB_ENABLE, 8'h05, 8'd0, 1'b1, 3'b101, 6'h3f); // green off
        add_step(CMD_SET_RGB_ENABLE, 8'h06, 8'd0, 1'b1, 3'b110, 6'h3f); // red off
        add_step(CMD_SET_RGB_ENABLE, 8'h07, 8'd0, 1'b0, 3'b111, 6'h3f);
        add_step(CMD_SET_BRIGHTNESS, 8'h2a, 8'd0, 1'b1, 3'b111, 6'h2a);
        add_step(CMD_SET_BRIGHTNESS, 8'h03, 8'd0, 1'b1, 3'b111, 6'h03);
    endtask

    task automatic apply_step(input step_t s);
        logic [15:0] px;
        int          idx;
        send_byte(s.opcode);
        if (s.opcode == CMD_WRITE_PIXEL) begin
            px  = 16'($urandom);
            idx = int'(s.arg0) * `PANEL_WIDTH + int'(s.arg1);
            send_byte(s.arg0);
            send_byte(s.arg1);
            send_byte(px[15:8]);
            send_byte(px[7:0]);
            fb_bytes[2 * idx]     = px[15:8]; // high byte at the even address
            fb_bytes[2 * idx + 1] = px[7:0];
            written[idx]          = 1'b1;
        end else if (s.opcode == CMD_SET_RGB_ENABLE || s.opcode == CMD_SET_BRIGHTNESS) begin
            send_byte(s.arg0);
        end
        cur_rgb    = s.exp_rgb;
        cur_bright = s.exp_bright;
        if (s.check) begin
            wait_frame();
            compare_frame();
        end
    endtask

    initial begin
        void'($urandom(70));
        rst_n = 1'b0;
        rx    = 1'b1;
        repeat (8) @(posedge clk_in);
        #DRIVE_DELAY;
        check(32'(oe_n), 1, "oe_n in reset");
        check(32'(latch), 0, "latch in reset");
        check(32'(clk_pixel), 0, "clk_pixel in reset");
        check(32'(rgb_top), 0, "rgb_top in reset");
        check(32'(rgb_bottom), 0, "rgb_bottom in reset");
        check(32'(row_addr), 0, "row_addr in reset");
        rst_n = 1'b1;

        load_table();
        foreach (steps[i])
            apply_step(steps[i]);

        check(32'(windows_checked > SLOTS), 1, "enable windows seen");
        $display("No errors");
        $finish;
    end
endmodule

// ==== design/led_matrix_top.sv ====
`timescale 1ns/1ns

module led_matrix_top (
    input  logic                      clk_in,
    input  logic                      rst_n,
    input  logic                      rx,
    output led_matrix_pkg::rgb_bits_t rgb_top,
    output led_matrix_pkg::rgb_bits_t rgb_bottom,
    output logic                      clk_pixel,
    output logic                      latch,
    output logic                      oe_n,
    output led_matrix_pkg::row_addr_t row_addr
);
    import led_matrix_pkg::*;

    // host side
    logic          rx_valid;
    logic [7:0]    rx_data;
    logic          wr_en;
    fb_addr_t      wr_addr;
    logic [7:0]    wr_data;
    rgb_bits_t     rgb_enable;
    plane_mask_t   brightness_enable;

    // panel side
    logic          rd_en;
    fb_word_addr_t rd_addr;
    rgb565_t       rd_data;

    pixel_fetch_if fetch_bus ();

    uart_rx u_uart_rx (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    command_decoder u_command_decoder (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .rx_valid          (rx_valid),
        .rx_data           (rx_data),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    framebuffer u_framebuffer (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    framebuffer_fetch u_framebuffer_fetch (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .fetch   (fetch_bus.fetch),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    matrix_scan u_matrix_scan (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .fetch             (fetch_bus.scan),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rgb_top           (rgb_top),
        .rgb_bottom        (rgb_bottom),
        .clk_pixel         (clk_pixel),
        .latch             (latch),
        .oe_n              (oe_n),
        .row_addr          (row_addr)
    );
endmodule

// ==== design/matrix_scan.sv ====
`timescale 1ns/1ns
`include "led_matrix_config.svh"

module matrix_scan (
    input  logic                        clk_in,
    input  logic                        rst_n,
    pixel_fetch_if.scan                 fetch,
    input  led_matrix_pkg::rgb_bits_t   rgb_enable,
    input  led_matrix_pkg::plane_mask_t brightness_enable,
    output led_matrix_pkg::rgb_bits_t   rgb_top,
    output led_matrix_pkg::rgb_bits_t   rgb_bottom,
    output logic                        clk_pixel,
    output logic                        latch,
    output logic                        oe_n,
    output led_matrix_pkg::row_addr_t   row_addr
);
    import led_matrix_pkg::*;

    localparam int PH_W    = $clog2(`FETCH_LATENCY + `PIXEL_CLK_DIV + 1);
    localparam int PLANE_W = $clog2(`COLOR_PLANES);
    localparam int OE_W    = $clog2((`OE_BASE_CYCLES << (`COLOR_PLANES - 1)) + 1);

    typedef enum logic [2:0] {
        S_FETCH,
        S_WAIT,
        S_LOW,
        S_HIGH,
        S_LATCH,
        S_SHOW
    } scan_state_t;

    scan_state_t        state;
    logic [PH_W-1:0]    phase_cnt;
    col_t               col_cnt;
    logic [PLANE_W-1:0] plane_cnt;
    row_addr_t          row_cnt;
    logic [OE_W-1:0]    oe_cnt; // remaining enable cycles
    plane_mask_t        plane_mask;

    assign fetch.fetch_req = (state == S_FETCH);
    assign fetch.col       = col_cnt;
    assign fetch.row_addr  = row_cnt;

    assign plane_mask = (plane_mask_t'(1) << plane_cnt) & brightness_enable;

    // red and blue widened to 6 bits by repeating their msb
    function automatic rgb_bits_t plane_bits(rgb565_t px, plane_mask_t mask, rgb_bits_t en);
        plane_mask_t red6;
        plane_mask_t blue6;
        red6  = {px.r, px.r[4]};
        blue6 = {px.b, px.b[4]};
        return {|(blue6 & mask), |(px.g & mask), |(red6 & mask)} & en;
    endfunction

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state      <= S_FETCH;
            phase_cnt  <= '0;
            col_cnt    <= '0;
            plane_cnt  <= '0;
            row_cnt    <= '0;
            oe_cnt     <= '0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
            clk_pixel  <= 1'b0;
            latch      <= 1'b0;
            oe_n       <= 1'b1;
            row_addr   <= '0;
        end else begin
            // enable window runs while the next plane shifts
            if (!oe_n) begin
                if (oe_cnt == OE_W'(1))
                    oe_n <= 1'b1;
                else
                    oe_cnt <= oe_cnt - 1'b1;
            end

            case (state)
                S_FETCH: begin
                    phase_cnt <= '0;
                    state     <= S_WAIT;
                end
                S_WAIT: begin
                    if (phase_cnt == PH_W'(`FETCH_LATENCY - 1)) begin
                        rgb_top    <= plane_bits(fetch.pixel_top, plane_mask, rgb_enable);
                        rgb_bottom <= plane_bits(fetch.pixel_bottom, plane_mask, rgb_enable);
                        phase_cnt  <= '0;
                        state      <= S_LOW;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                S_LOW: begin
                    if (phase_cnt == PH_W'(`PIXEL_CLK_DIV - 1)) begin
                        clk_pixel <= 1'b1; // data already settled
                        phase_cnt <= '0;
                        state     <= S_HIGH;
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                S_HIGH: begin
                    if (phase_cnt == PH_W'(`PIXEL_CLK_DIV - 1)) begin
                        clk_pixel <= 1'b0;
                        phase_cnt <= '0;
                        if (col_cnt == col_t'(`PANEL_WIDTH - 1)) begin
                            col_cnt <= '0;
                            oe_n    <= 1'b1; // blank before latching
                            state   <= S_LATCH;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                            state   <= S_FETCH;
                        end
                    end else begin
                        phase_cnt <= phase_cnt + 1'b1;
                    end
                end
                S_LATCH: begin
                    latch    <= 1'b1;
                    row_addr <= row_cnt;
                    state    <= S_SHOW;
                end
                default: begin
                    latch  <= 1'b0;
                    oe_n   <= 1'b0;
                    oe_cnt <= OE_W'(`OE_BASE_CYCLES) << plane_cnt; // binary weighted
                    if (plane_cnt == PLANE_W'(`COLOR_PLANES - 1)) begin
                        plane_cnt <= '0;
                        row_cnt   <= row_cnt + 1'b1; // wraps after the last pair
                    end else begin
                        plane_cnt <= plane_cnt + 1'b1;
                    end
                    state <= S_FETCH;
                end
            endcase
        end
    end
endmodule

// ==== design/framebuffer_fetch.sv ====
`timescale 1ns/1ns
`include "led_matrix_config.svh"

module framebuffer_fetch (
    input  logic                          clk_in,
    input  logic                          rst_n,
    pixel_fetch_if.fetch                  fetch,
    output logic                          rd_en,
    output led_matrix_pkg::fb_word_addr_t rd_addr,
    input  led_matrix_pkg::rgb565_t       rd_data
);
    import led_matrix_pkg::*;

    logic      req_d1; // bottom read in flight
    logic      req_d2; // both pixels on hand
    col_t      col_q;
    row_addr_t row_q;
    row_t      row_bottom;
    rgb565_t   top_hold;

    assign row_bottom = row_t'(row_q) + row_t'(`PANEL_HALF_HEIGHT);

    // top pixel straight from the request, bottom one a cycle later
    assign rd_en   = fetch.fetch_req | req_d1;
    assign rd_addr = req_d1 ? {row_bottom, col_q} : {row_t'(fetch.row_addr), fetch.col};

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            req_d1 <= 1'b0;
            req_d2 <= 1'b0;
        end else begin
            req_d1 <= fetch.fetch_req;
            req_d2 <= req_d1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (fetch.fetch_req) begin
            col_q <= fetch.col;
            row_q <= fetch.row_addr;
        end
        if (req_d1)
            top_hold <= rd_data;
        // both halves update together
        if (req_d2) begin
            fetch.pixel_top    <= top_hold;
            fetch.pixel_bottom <= rd_data;
        end
    end
endmodule

// ==== design/framebuffer.sv ====
`timescale 1ns/1ns
`include "led_matrix_config.svh"

module framebuffer (
    input  logic                          clk_in,
    input  logic                          wr_en,
    input  led_matrix_pkg::fb_addr_t      wr_addr,
    input  logic [7:0]                    wr_data,
    input  logic                          rd_en,
    input  led_matrix_pkg::fb_word_addr_t rd_addr,
    output led_matrix_pkg::rgb565_t       rd_data
);
    import led_matrix_pkg::*;

    localparam int BANK_DEPTH = `PANEL_WIDTH * `PANEL_HEIGHT * `BYTES_PER_PIXEL / 2;

    logic [7:0] bank_even [BANK_DEPTH]; // high bytes
    logic [7:0] bank_odd  [BANK_DEPTH]; // low bytes

    fb_word_addr_t wr_word;

    assign wr_word = wr_addr[$bits(fb_addr_t)-1:1];

    // port a, byte writes
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_addr[0])
                bank_odd[wr_word] <= wr_data;
            else
                bank_even[wr_word] <= wr_data;
        end
    end

    // port b, registered word read
    always_ff @(posedge clk_in) begin
        if (rd_en)
            rd_data <= {bank_even[rd_addr], bank_odd[rd_addr]};
    end
endmodule

// ==== design/command_decoder.sv ====
`timescale 1ns/1ns

module command_decoder (
    input  logic                        clk_in,
    input  logic                        rst_n,
    input  logic                        rx_valid,
    input  logic [7:0]                  rx_data,
    output logic                        wr_en,
    output led_matrix_pkg::fb_addr_t    wr_addr,
    output logic [7:0]                  wr_data,
    output led_matrix_pkg::rgb_bits_t   rgb_enable,
    output led_matrix_pkg::plane_mask_t brightness_enable
);
    import led_matrix_pkg::*;

    typedef enum logic {
        D_OPCODE,
        D_ARGS
    } dec_state_t;

    dec_state_t  state;
    cmd_opcode_t opcode;
    logic [1:0]  arg_idx; // argument number within the command
    row_t        row_q;
    col_t        col_q;
    logic        arg_strobe;

    assign arg_strobe = rx_valid && state == D_ARGS;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state             <= D_OPCODE;
            arg_idx           <= '0;
            wr_en             <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid && state == D_OPCODE) begin
                arg_idx <= '0;
                // unknown bytes are dropped here
                if (rx_data inside {CMD_SET_BRIGHTNESS, CMD_SET_RGB_ENABLE, CMD_WRITE_PIXEL})
                    state <= D_ARGS;
            end else if (arg_strobe) begin
                arg_idx <= arg_idx + 1'b1;
                case (opcode)
                    CMD_SET_BRIGHTNESS: begin
                        brightness_enable <= rx_data[5:0];
                        state             <= D_OPCODE;
                    end
                    CMD_SET_RGB_ENABLE: begin
                        rgb_enable <= rx_data[2:0];
                        state      <= D_OPCODE;
                    end
                    default: begin
                        wr_en <= arg_idx[1]; // args 2 and 3 carry pixel bytes
                        if (arg_idx == 2'd3) state <= D_OPCODE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rx_valid && state == D_OPCODE)
            opcode <= cmd_opcode_t'(rx_data);
        if (arg_strobe && opcode == CMD_WRITE_PIXEL) begin
            case (arg_idx)
                2'd0: row_q <= row_t'(rx_data);
                2'd1: col_q <= col_t'(rx_data);
                default: begin
                    wr_addr <= {row_q, col_q, arg_idx[0]}; // high byte even, low byte odd
                    wr_data <= rx_data;
                end
            endcase
        end
    end
endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ns
`include "led_matrix_config.svh"

module uart_rx (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       rx,
    output logic       rx_valid,
    output logic [7:0] rx_data
);
    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int HALF_BIT = `UART_CLKS_PER_BIT / 2;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0] bit_idx;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx) state <= RX_START; // falling edge of start bit
                end
                RX_START: begin
                    if (clk_cnt == CNT_W'(HALF_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx ? RX_IDLE : RX_DATA; // glitch, back to idle
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1)) begin
                        rx_valid <= rx; // framing error drops the byte
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first, shift in from the top
    always_ff @(posedge clk_in) begin
        if (state == RX_DATA && clk_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1))
            rx_data <= {rx, rx_data[7:1]};
    end
endmodule

// ==== design/pixel_fetch_if.sv ====
`timescale 1ns/1ns

// scan engine asks for one column, fetch unit answers FETCH_LATENCY cycles later
interface pixel_fetch_if;
    logic                      fetch_req;
    led_matrix_pkg::col_t      col;
    led_matrix_pkg::row_addr_t row_addr;
    led_matrix_pkg::rgb565_t   pixel_top;
    led_matrix_pkg::rgb565_t   pixel_bottom;

    modport scan (
        output fetch_req, col, row_addr,
        input  pixel_top, pixel_bottom
    );

    modport fetch (
        input  fetch_req, col, row_addr,
        output pixel_top, pixel_bottom
    );
endinterface

// ==== design/led_matrix_pkg.sv ====
`include "led_matrix_config.svh"

package led_matrix_pkg;

    // rgb565 as stored in the framebuffer
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef logic [$clog2(`PANEL_WIDTH*`PANEL_HEIGHT*`BYTES_PER_PIXEL)-1:0] fb_addr_t; // byte
    typedef logic [$clog2(`PANEL_WIDTH*`PANEL_HEIGHT)-1:0] fb_word_addr_t; // pixel

    typedef logic [$clog2(`PANEL_WIDTH)-1:0] col_t;
    typedef logic [$clog2(`PANEL_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(`PANEL_HALF_HEIGHT)-1:0] row_addr_t;

    typedef logic [`COLOR_PLANES-1:0] plane_mask_t;

    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] rgb_bits_t;

    typedef enum logic [7:0] {
        CMD_SET_BRIGHTNESS = 8'h01,
        CMD_SET_RGB_ENABLE = 8'h02,
        CMD_WRITE_PIXEL    = 8'h03
    } cmd_opcode_t;

endpackage

// ==== design/led_matrix_config.svh ====
`ifndef LED_MATRIX_CONFIG_SVH
`define LED_MATRIX_CONFIG_SVH

// panel geometry
`define PANEL_WIDTH 64
`define PANEL_HEIGHT 32
`define PANEL_HALF_HEIGHT 16 // also the number of row addresses
`define BYTES_PER_PIXEL 2

// colour depth, bit planes per row pair
`define COLOR_PLANES 6

// timing, all in clk_in cycles
`define UART_CLKS_PER_BIT 8
`define PIXEL_CLK_DIV 2 // half period of clk_pixel
`define OE_BASE_CYCLES 4 // enable window of plane 0
`define FETCH_LATENCY 3 // request to valid pixels

`endif
